//--- hdl/frontend_defines.svh
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// machine word and pc width
`define XLEN 32

// instruction queue entries
`define FQ_DEPTH 16

// queue pointer width, count is one bit wider
`define FQ_PTR_W 4

`endif

//--- hdl/frontend_pkg.sv
package frontend_pkg;

`include "frontend_defines.svh"

    // one queued instruction word with its pc
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } fetch_entry_t;

    // coarse instruction class seen by issue
    typedef enum logic [3:0] {
        OP_R,
        OP_I,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_SYSTEM,
        OP_ILLEGAL
    } op_class_e;

    // decoder result for one word
    typedef struct packed {
        op_class_e        op_class;
        logic [2:0]       funct3;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        // already sign-extended
        logic [`XLEN-1:0] imm;
        logic             uses_rs1;
        logic             uses_rs2;
        logic             writes_rd;
    } decoded_instr_t;

    // one registered issue lane
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        decoded_instr_t   dec;
        // lane 1 only, raw hazard on the older lane
        logic             dep_on_lane0;
    } dec_lane_t;

endpackage

//--- hdl/fetch_queue.sv
`timescale 1ns/10ps

`include "frontend_defines.svh"

module fetch_queue import frontend_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               push_valid,
    input  logic               push_two,
    input  logic [`XLEN-1:0]   push_pc,
    input  logic [63:0]        push_bundle,
    input  logic [1:0]         pop_count,
    output fetch_entry_t       head0,
    output fetch_entry_t       head1,
    output logic [1:0]         head_count,
    output logic               full
);

    // single step for pointer wrap arithmetic
    localparam logic [`FQ_PTR_W-1:0] PTR_INC = 1;
    // fewer than two free slots from here on
    localparam logic [`FQ_PTR_W:0] FULL_LVL = `FQ_DEPTH - 1;

    // circular storage, only the pointers say what is live
    fetch_entry_t mem [`FQ_DEPTH];

    logic [`FQ_PTR_W-1:0] head;
    logic [`FQ_PTR_W-1:0] tail;
    logic [`FQ_PTR_W:0]   count;

    logic [`FQ_PTR_W-1:0] head_p1;
    logic [`FQ_PTR_W-1:0] tail_p1;
    logic                 push_ok;
    logic [1:0]           push_n;
    fetch_entry_t         push_old;
    fetch_entry_t         push_young;

    assign head_p1 = head + PTR_INC;
    assign tail_p1 = tail + PTR_INC;

    // older word sits in the upper half of the bundle
    assign push_old.pc      = push_pc;
    assign push_old.instr   = push_bundle[63:32];
    assign push_young.pc    = push_pc + `XLEN'd4;
    assign push_young.instr = push_bundle[31:0];

    // pushes while full or during flush are dropped
    assign push_ok = push_valid && !full && !flush;

    always_comb begin
        push_n = 2'd0;
        if (push_ok) begin
            push_n = push_two ? 2'd2 : 2'd1;
        end
    end

    // oldest two entries, read straight from the array
    assign head0 = mem[head];
    assign head1 = mem[head_p1];

    // at most two entries offered per cycle
    always_comb begin
        if (count >= 2) begin
            head_count = 2'd2;
        end else begin
            head_count = count[1:0];
        end
    end

    assign full = (count >= FULL_LVL);

    // payload write at tail, no reset needed
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[tail] <= push_old;
            if (push_two) begin
                mem[tail_p1] <= push_young;
            end
        end
    end

    // pointer and count update
    // push and pop may land on the same edge
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + {{(`FQ_PTR_W-2){1'b0}}, pop_count};
            tail  <= tail + {{(`FQ_PTR_W-2){1'b0}}, push_n};
            count <= count + {{(`FQ_PTR_W-1){1'b0}}, push_n}
                           - {{(`FQ_PTR_W-1){1'b0}}, pop_count};
        end
    end

endmodule

//--- hdl/rv32_decoder.sv
`timescale 1ns/10ps

`include "frontend_defines.svh"

module rv32_decoder import frontend_pkg::*; (
    input  logic [31:0]    instr,
    output decoded_instr_t dec
);

    // base opcodes, bits [6:0]
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             rd_wr;

    // immediate formats, sign bit is always instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        // fields come out raw whatever the class
        dec.op_class = OP_ILLEGAL;
        dec.funct3   = instr[14:12];
        dec.rd       = instr[11:7];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.imm      = '0;
        dec.uses_rs1 = 1'b0;
        dec.uses_rs2 = 1'b0;
        rd_wr        = 1'b0;
        case (instr[6:0])
            OPC_R: begin
                dec.op_class = OP_R;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                rd_wr        = 1'b1;
            end
            OPC_I: begin
                dec.op_class = OP_I;
                dec.imm      = imm_i;
                dec.uses_rs1 = 1'b1;
                rd_wr        = 1'b1;
            end
            OPC_LOAD: begin
                dec.op_class = OP_LOAD;
                dec.imm      = imm_i;
                dec.uses_rs1 = 1'b1;
                rd_wr        = 1'b1;
            end
            OPC_STORE: begin
                dec.op_class = OP_STORE;
                dec.imm      = imm_s;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                dec.op_class = OP_BRANCH;
                dec.imm      = imm_b;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            OPC_LUI: begin
                dec.op_class = OP_LUI;
                dec.imm      = imm_u;
                rd_wr        = 1'b1;
            end
            OPC_AUIPC: begin
                dec.op_class = OP_AUIPC;
                dec.imm      = imm_u;
                rd_wr        = 1'b1;
            end
            OPC_JAL: begin
                dec.op_class = OP_JAL;
                dec.imm      = imm_j;
                rd_wr        = 1'b1;
            end
            OPC_JALR: begin
                dec.op_class = OP_JALR;
                dec.imm      = imm_i;
                dec.uses_rs1 = 1'b1;
                rd_wr        = 1'b1;
            end
            OPC_SYSTEM: begin
                dec.op_class = OP_SYSTEM;
                dec.imm      = imm_i;
                // csr ops, register form reads rs1
                // ecall and ebreak touch no registers
                if (instr[14:12] != 3'b000) begin
                    dec.uses_rs1 = !instr[14];
                    rd_wr        = 1'b1;
                end
            end
            default: begin
                dec.op_class = OP_ILLEGAL;
            end
        endcase
        // x0 as destination is no write
        dec.writes_rd = rd_wr && (instr[11:7] != 5'd0);
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import frontend_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    input  logic         stall,
    input  fetch_entry_t head0,
    input  fetch_entry_t head1,
    input  logic [1:0]   head_count,
    output logic [1:0]   pop_count,
    output dec_lane_t    lane0,
    output dec_lane_t    lane1
);

    decoded_instr_t dec0;
    decoded_instr_t dec1;
    logic           rs1_hit;
    logic           rs2_hit;
    logic           dep;

    rv32_decoder dec0_i (
        .instr (head0.instr),
        .dec   (dec0)
    );

    rv32_decoder dec1_i (
        .instr (head1.instr),
        .dec   (dec1)
    );

    // retire whatever is offered unless issue is stalled
    assign pop_count = stall ? 2'd0 : head_count;

    // raw check, younger lane against older lane's rd
    // writes_rd already excludes x0
    assign rs1_hit = dec1.uses_rs1 && (dec1.rs1 == dec0.rd);
    assign rs2_hit = dec1.uses_rs2 && (dec1.rs2 == dec0.rd);
    assign dep     = dec0.writes_rd && (rs1_hit || rs2_hit);

    // lane registers, held while stalled
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            lane0.valid <= 1'b0;
            lane1.valid <= 1'b0;
        end else if (!stall) begin
            lane0.valid        <= (head_count != 2'd0);
            lane0.pc           <= head0.pc;
            lane0.dec          <= dec0;
            lane0.dep_on_lane0 <= 1'b0;
            lane1.valid        <= (head_count == 2'd2);
            lane1.pc           <= head1.pc;
            lane1.dec          <= dec1;
            lane1.dep_on_lane0 <= dep;
        end
    end

endmodule

//--- hdl/frontend_top.sv
`timescale 1ns/10ps

`include "frontend_defines.svh"

module frontend_top import frontend_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             stall,
    input  logic             fetch_valid,
    input  logic             fetch_two,
    input  logic [`XLEN-1:0] fetch_pc,
    input  logic [63:0]      fetch_bundle,
    output logic             fetch_full,
    output dec_lane_t        lane0,
    output dec_lane_t        lane1
);

    // queue head toward decode
    fetch_entry_t head0;
    fetch_entry_t head1;
    logic [1:0]   head_count;
    // retire count back to the queue
    logic [1:0]   pop_count;

    fetch_queue fetch_queue_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .push_valid  (fetch_valid),
        .push_two    (fetch_two),
        .push_pc     (fetch_pc),
        .push_bundle (fetch_bundle),
        .pop_count   (pop_count),
        .head0       (head0),
        .head1       (head1),
        .head_count  (head_count),
        .full        (fetch_full)
    );

    decode_stage decode_stage_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .stall      (stall),
        .head0      (head0),
        .head1      (head1),
        .head_count (head_count),
        .pop_count  (pop_count),
        .lane0      (lane0),
        .lane1      (lane1)
    );

endmodule

//--- tb/frontend_tb.sv
`timescale 1ns/10ps

`include "frontend_defines.svh"

module frontend_tb import frontend_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic             clk = 1'b0;
    logic             reset;
    logic             flush;
    logic             stall;
    logic             fetch_valid;
    logic             fetch_two;
    logic [`XLEN-1:0] fetch_pc;
    logic [63:0]      fetch_bundle;
    logic             fetch_full;
    dec_lane_t        lane0;
    dec_lane_t        lane1;

    // expected stream with the oldest entry first
    logic [`XLEN-1:0] exp_pc_q[$];
    decoded_instr_t   exp_dec_q[$];
    // expected decode of the bundle on the pins
    decoded_instr_t   drv_dec0;
    decoded_instr_t   drv_dec1;
    // entries the queue should hold right now
    int               model_count;
    int               pops;
    int               loaded_n;
    // what the last edge did to the lanes
    logic             lanes_loaded;
    logic             lanes_held;
    logic             lanes_cleared;
    dec_lane_t        last0;
    dec_lane_t        last1;
    int               hold_cnt;
    logic             rand_stall;
    int               mismatch_count;
    int               fault_count;

    frontend_top frontend_top_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .stall        (stall),
        .fetch_valid  (fetch_valid),
        .fetch_two    (fetch_two),
        .fetch_pc     (fetch_pc),
        .fetch_bundle (fetch_bundle),
        .fetch_full   (fetch_full),
        .lane0        (lane0),
        .lane1        (lane1)
    );

    always #4 clk = ~clk;

    task automatic check_lane(input int idx, input dec_lane_t got,
                              input logic [`XLEN-1:0] pc, input decoded_instr_t exp);
        if (got.pc !== pc || got.dec !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: lane%0d pc %h dec %h, expected pc %h dec %h",
                     $time, idx, got.pc, got.dec, pc, exp);
        end
    endtask

    task automatic check_held(input int idx, input dec_lane_t got, input dec_lane_t was);
        if (got !== was) begin
            mismatch_count++;
            $display("MISMATCH at %0t: lane%0d changed under stall, %h was %h",
                     $time, idx, got, was);
        end
    endtask

    task automatic check_valid(input int got, input int exp);
        if (got != exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %0d valid lanes, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_dep(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: dep_on_lane0 %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: fetch_full %b, expected %b", $time, got, exp);
        end
    endtask

    // raw hazard when the older lane writes a register the younger reads
    function automatic logic dep_rule(input decoded_instr_t older, input decoded_instr_t younger);
        return older.writes_rd && ((younger.uses_rs1 && younger.rs1 == older.rd) ||
                                   (younger.uses_rs2 && younger.rs2 == older.rd));
    endfunction

    task automatic take_expected(input int idx, input dec_lane_t got);
        if (exp_pc_q.size() == 0) begin
            mismatch_count++;
            $display("MISMATCH at %0t: lane%0d pc %h was never pushed", $time, idx, got.pc);
        end else begin
            check_lane(idx, got, exp_pc_q.pop_front(), exp_dec_q.pop_front());
        end
    endtask

    // queue occupancy model sampled at the edge
    always @(posedge clk) begin
        lanes_cleared = reset || flush;
        lanes_held    = !lanes_cleared && stall;
        lanes_loaded  = !lanes_cleared && !stall;
        pops = 0;
        if (lanes_cleared) begin
            model_count = 0;
            exp_pc_q.delete();
            exp_dec_q.delete();
        end else begin
            if (!stall) begin
                pops = (model_count >= 2) ? 2 : model_count;
            end
            if (fetch_valid) begin
                exp_pc_q.push_back(fetch_pc);
                exp_dec_q.push_back(drv_dec0);
                model_count++;
                if (fetch_two) begin
                    exp_pc_q.push_back(fetch_pc + `XLEN'd4);
                    exp_dec_q.push_back(drv_dec1);
                    model_count++;
                end
            end
            model_count = model_count - pops;
        end
        loaded_n = pops;
    end

    // mid-cycle compare of the registered outputs
    always @(negedge clk) begin
        check_full(fetch_full, model_count >= 15);
        if (lanes_cleared) begin
            check_valid(int'(lane0.valid) + int'(lane1.valid), 0);
        end else if (lanes_held) begin
            check_held(0, lane0, last0);
            check_held(1, lane1, last1);
        end else if (lanes_loaded) begin
            check_valid(int'(lane0.valid) + int'(lane1.valid), loaded_n);
            if (lane0.valid) begin
                take_expected(0, lane0);
            end
            if (lane1.valid) begin
                take_expected(1, lane1);
            end
        end
        if (!lanes_cleared && lane0.valid && lane1.valid) begin
            check_dep(lane1.dep_on_lane0, dep_rule(lane0.dec, lane1.dec));
        end
        last0 = lane0;
        last1 = lane1;
    end

    // one clock with inputs changed 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (hold_cnt > 0) begin
            hold_cnt--;
        end
        if (hold_cnt > 0) begin
            stall = 1'b1;
        end else if (rand_stall) begin
            stall = (($urandom % 3) == 0);
        end else begin
            stall = 1'b0;
        end
    endtask

    task automatic send_bundle(input logic [`XLEN-1:0] pc, input logic two,
                               input logic [31:0] w0, input logic [31:0] w1,
                               input decoded_instr_t d0, input decoded_instr_t d1);
        int waited;
        waited = 0;
        // source may not push while the queue is nearly full
        while (fetch_full && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (fetch_full) begin
            fault_count++;
            $display("timeout at %0t: fetch_full never dropped for push at pc %h", $time, pc);
        end else begin
            fetch_valid  = 1'b1;
            fetch_two    = two;
            fetch_pc     = pc;
            fetch_bundle = {w0, w1};
            drv_dec0     = d0;
            drv_dec1     = d1;
            next_cycle();
            fetch_valid  = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_pc_q.size() != 0 || model_count != 0) && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_pc_q.size() != 0 || model_count != 0) begin
            fault_count++;
            $display("timeout at %0t: %0d expected entries never reached the lanes",
                     $time, exp_pc_q.size());
        end
    endtask

    task automatic do_flush();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
    endtask

    task automatic read_expected(input int fd, output decoded_instr_t d, output logic ok);
        logic [3:0]  cls;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        u1;
        logic        u2;
        logic        wr;
        int          n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", cls, f3, rd, rs1, rs2, imm, u1, u2, wr);
        ok = (n == 9);
        d.op_class  = op_class_e'(cls);
        d.funct3    = f3;
        d.rd        = rd;
        d.rs1       = rs1;
        d.rs2       = rs2;
        d.imm       = imm;
        d.uses_rs1  = u1;
        d.uses_rs2  = u2;
        d.writes_rd = wr;
    endtask

    initial begin
        int             fd;
        int             c;
        int             n;
        int             arg;
        logic [7:0]     ch;
        logic [31:0]    pc;
        logic [31:0]    w0;
        logic [31:0]    w1;
        logic           two;
        logic           ok0;
        logic           ok1;
        decoded_instr_t d0;
        decoded_instr_t d1;
        void'($urandom(32'hc7ef76a1));
        reset = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        fetch_valid = 1'b0;
        fetch_two = 1'b0;
        fetch_pc = '0;
        fetch_bundle = '0;
        drv_dec0 = '0;
        drv_dec1 = '0;
        model_count = 0;
        hold_cnt = 0;
        rand_stall = 1'b0;
        mismatch_count = 0;
        fault_count = 0;
        lanes_loaded = 1'b0;
        lanes_held = 1'b0;
        lanes_cleared = 1'b0;
        repeat (10) begin
            next_cycle();
        end
        reset = 1'b0;
        fd = $fopen("tb/frontend_cases.txt", "r");
        if (fd == 0) begin
            fault_count++;
            $display("could not open tb/frontend_cases.txt");
        end
        // one command letter per line with its fields after it
        c = 0;
        while (fd != 0 && c >= 0 && fault_count == 0) begin
            c = $fgetc(fd);
            ch = c[7:0];
            if (c >= 0) begin
                case (ch)
                    "P": begin
                        n = $fscanf(fd, "%h %h %h %h", pc, two, w0, w1);
                        read_expected(fd, d0, ok0);
                        read_expected(fd, d1, ok1);
                        if (n != 4 || !ok0 || !ok1) begin
                            fault_count++;
                            $display("malformed push line in the cases file");
                        end else begin
                            send_bundle(pc, two, w0, w1, d0, d1);
                        end
                    end
                    "H": begin
                        n = $fscanf(fd, "%d", arg);
                        if (n != 1) begin
                            fault_count++;
                            $display("malformed stall hold line in the cases file");
                        end else begin
                            hold_cnt = arg;
                            stall = (arg > 0);
                        end
                    end
                    "R": begin
                        n = $fscanf(fd, "%d", arg);
                        if (n != 1) begin
                            fault_count++;
                            $display("malformed random stall line in the cases file");
                        end else begin
                            rand_stall = (arg != 0);
                        end
                    end
                    "F": do_flush();
                    "D": wait_drained();
                    "#": begin
                        while (c >= 0 && c != 10) begin
                            c = $fgetc(fd);
                        end
                        c = 0;
                    end
                    " ", "\n", "\r", "\t": ;
                    default: begin
                        fault_count++;
                        $display("unknown command '%c' in the cases file", ch);
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (fault_count == 0) begin
            rand_stall = 1'b0;
            wait_drained();
            next_cycle();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_queue.sv
hdl/rv32_decoder.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
tb/frontend_tb.sv

//--- run.sh
#!/bin/sh
# build the frontend testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module frontend_tb -f all.f
out=$(./obj_dir/Vfrontend_tb)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"

//--- tb/frontend_cases.txt
# P pc two word0 word1, then per word: class funct3 rd rs1 rs2 imm uses_rs1 uses_rs2 writes_rd
# F flush, H n stall held n cycles, R n random stall off/on, D wait until the lanes drain
P 00001000 1 00500093 ffe08113 1 0 01 00 05 00000005 1 0 1 1 0 02 01 1e fffffffe 1 0 1
P 00001008 1 002081b3 ffc1a203 0 0 03 01 02 00000000 1 1 1 2 2 04 03 1c fffffffc 1 0 1
P 00001010 0 fe412c23 00000000 3 2 18 02 04 fffffff8 1 1 0 0 0 00 00 00 00000000 0 0 0
P 00001014 1 fe2088e3 123452b7 4 0 11 01 02 fffffff0 1 1 0 5 5 05 08 03 12345000 0 0 1
P 00001020 1 00001017 ff9ff0ef 6 1 00 00 00 00001000 0 0 0 7 7 01 1f 19 fffffff8 0 0 1
P 00001028 1 00008067 00000073 8 0 00 01 00 00000000 1 0 0 9 0 00 00 00 00000000 0 0 0
P 00001030 1 30029373 ffffffff 9 1 06 05 00 00000300 1 0 1 a 7 1f 1f 1f 00000000 0 0 0
P 00001038 0 00208033 00000000 0 0 00 01 02 00000000 1 1 0 0 0 00 00 00 00000000 0 0 0
D
R 1
P 00001100 1 002081b3 ffc1a203 0 0 03 01 02 00000000 1 1 1 2 2 04 03 1c fffffffc 1 0 1
P 00001108 1 00500093 ffe08113 1 0 01 00 05 00000005 1 0 1 1 0 02 01 1e fffffffe 1 0 1
P 00001110 1 fe412c23 fe2088e3 3 2 18 02 04 fffffff8 1 1 0 4 0 11 01 02 fffffff0 1 1 0
P 00001118 1 123452b7 30029373 5 5 05 08 03 12345000 0 0 1 9 1 06 05 00 00000300 1 0 1
P 00001120 0 ff9ff0ef 00000000 7 7 01 1f 19 fffffff8 0 0 1 0 0 00 00 00 00000000 0 0 0
D
R 0
# fill the queue under a held stall, the last push has to wait for room
H 24
P 00002000 1 00500093 ffe08113 1 0 01 00 05 00000005 1 0 1 1 0 02 01 1e fffffffe 1 0 1
P 00002008 1 002081b3 ffc1a203 0 0 03 01 02 00000000 1 1 1 2 2 04 03 1c fffffffc 1 0 1
P 00002010 1 fe412c23 fe2088e3 3 2 18 02 04 fffffff8 1 1 0 4 0 11 01 02 fffffff0 1 1 0
P 00002018 1 123452b7 00001017 5 5 05 08 03 12345000 0 0 1 6 1 00 00 00 00001000 0 0 0
P 00002020 1 ff9ff0ef 00008067 7 7 01 1f 19 fffffff8 0 0 1 8 0 00 01 00 00000000 1 0 0
P 00002028 1 00000073 30029373 9 0 00 00 00 00000000 0 0 0 9 1 06 05 00 00000300 1 0 1
P 00002030 1 ffffffff 00208033 a 7 1f 1f 1f 00000000 0 0 0 0 0 00 01 02 00000000 1 1 0
P 00002038 0 00500093 00000000 1 0 01 00 05 00000005 1 0 1 0 0 00 00 00 00000000 0 0 0
P 0000203c 1 ffe08113 002081b3 1 0 02 01 1e fffffffe 1 0 1 0 0 03 01 02 00000000 1 1 1
D
# queued entries are dropped by the flush
H 4
P 00003000 1 00500093 ffe08113 1 0 01 00 05 00000005 1 0 1 1 0 02 01 1e fffffffe 1 0 1
P 00003008 1 002081b3 ffc1a203 0 0 03 01 02 00000000 1 1 1 2 2 04 03 1c fffffffc 1 0 1
F
P 00004000 1 30029373 00000073 9 1 06 05 00 00000300 1 0 1 9 0 00 00 00 00000000 0 0 0
D
